/* rtl/dcache_pkg.sv */
/*
 * Data cache package
 * Geometry, address fields, request and response structs,
 * performance counter struct and FSM encodings
 */
package dcache_pkg;

    // Cache geometry
    localparam int WORD_W         = 32;
    localparam int WORDS_PER_LINE = 4;
    localparam int NUM_LINES      = 16;
    localparam int WSEL_W         = 2;
    localparam int INDEX_W        = 4;
    localparam int CTAG_W         = 4;
    localparam int ADDR_W         = CTAG_W + INDEX_W + WSEL_W;
    localparam int REQ_TAG_W      = 4;
    localparam int PERF_CTR_W     = 16;

    typedef logic [WORD_W-1:0]                     word_t;
    // Word 0 sits in the low bits
    typedef logic [WORDS_PER_LINE-1:0][WORD_W-1:0] line_t;
    typedef logic [ADDR_W-1:0]                     word_addr_t;
    typedef logic [CTAG_W+INDEX_W-1:0]             line_addr_t;
    typedef logic [INDEX_W-1:0]                    index_t;
    typedef logic [CTAG_W-1:0]                     cache_tag_t;
    typedef logic [WSEL_W-1:0]                     wsel_t;
    typedef logic [REQ_TAG_W-1:0]                  req_tag_t;
    typedef logic [PERF_CTR_W-1:0]                 perf_ctr_t;

    typedef enum logic {
        OP_READ,
        OP_WRITE
    } req_op_e;

    typedef struct packed {
        req_op_e    op;
        word_addr_t addr;
        word_t      data;
        req_tag_t   tag;
    } core_req_t;

    typedef struct packed {
        word_t    data;
        req_tag_t tag;
    } core_rsp_t;

    // Reads only use line_addr
    typedef struct packed {
        req_op_e    op;
        line_addr_t line_addr;
        wsel_t      wsel;
        word_t      data;
    } mem_req_t;

    typedef struct packed {
        line_t line;
    } mem_rsp_t;

    typedef struct packed {
        perf_ctr_t reads;
        perf_ctr_t writes;
        perf_ctr_t read_misses;
        perf_ctr_t write_misses;
    } perf_cnt_t;

    typedef enum logic [2:0] {
        S_IDLE,
        S_LOOKUP,
        S_MEM_RD,
        S_MEM_WAIT,
        S_MEM_WR,
        S_RESPOND
    } ctrl_state_e;

endpackage

/* rtl/dcache_tag_store.sv */
/*
 * Tag store
 * Per-line valid bits and tags, registered hit result
 * one cycle after the lookup address
 */
`timescale 1ns/1ps

module dcache_tag_store (
    input  logic                   clk,
    input  logic                   reset,
    input  dcache_pkg::line_addr_t lookup_addr_i,
    output logic                   hit_o,
    input  logic                   fill_en_i,
    input  dcache_pkg::line_addr_t fill_addr_i
);
    import dcache_pkg::*;

    cache_tag_t           tag_mem [NUM_LINES];
    logic [NUM_LINES-1:0] valid_q;

    index_t     lk_index;
    cache_tag_t lk_tag;
    index_t     fill_index;
    cache_tag_t fill_tag;

    // Registered lookup result
    cache_tag_t rd_tag_q;
    cache_tag_t lk_tag_q;
    logic       rd_valid_q;

    // Line address is tag above index
    assign lk_index   = lookup_addr_i[INDEX_W-1:0];
    assign lk_tag     = lookup_addr_i[CTAG_W+INDEX_W-1:INDEX_W];
    assign fill_index = fill_addr_i[INDEX_W-1:0];
    assign fill_tag   = fill_addr_i[CTAG_W+INDEX_W-1:INDEX_W];

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q    <= '0;
            rd_valid_q <= 1'b0;
        end else begin
            if (fill_en_i) begin
                valid_q[fill_index] <= 1'b1;
            end
            rd_valid_q <= valid_q[lk_index];
        end
    end

    always_ff @(posedge clk) begin
        if (fill_en_i) begin
            tag_mem[fill_index] <= fill_tag;
        end
        rd_tag_q <= tag_mem[lk_index];
        lk_tag_q <= lk_tag;
    end

    assign hit_o = rd_valid_q && (rd_tag_q == lk_tag_q);

endmodule

/* rtl/dcache_data_store.sv */
/*
 * Data store
 * Line storage with a registered word read,
 * whole-line fill and single word write
 */
`timescale 1ns/1ps

module dcache_data_store (
    input  logic                   clk,
    input  dcache_pkg::word_addr_t rd_addr_i,
    output dcache_pkg::word_t      rd_word_o,
    input  logic                   fill_en_i,
    input  dcache_pkg::index_t     fill_index_i,
    input  dcache_pkg::line_t      fill_line_i,
    input  logic                   wr_en_i,
    input  dcache_pkg::word_addr_t wr_addr_i,
    input  dcache_pkg::word_t      wr_word_i
);
    import dcache_pkg::*;

    line_t  line_mem [NUM_LINES];
    word_t  rd_word_q;

    index_t rd_index;
    wsel_t  rd_wsel;
    index_t wr_index;
    wsel_t  wr_wsel;

    assign rd_index = rd_addr_i[WSEL_W +: INDEX_W];
    assign rd_wsel  = rd_addr_i[WSEL_W-1:0];
    assign wr_index = wr_addr_i[WSEL_W +: INDEX_W];
    assign wr_wsel  = wr_addr_i[WSEL_W-1:0];

    always_ff @(posedge clk) begin
        if (fill_en_i) begin
            line_mem[fill_index_i] <= fill_line_i;
        end else if (wr_en_i) begin
            line_mem[wr_index][wr_wsel] <= wr_word_i;
        end
        rd_word_q <= line_mem[rd_index][rd_wsel];
    end

    assign rd_word_o = rd_word_q;

    // Fill comes from a read miss, write from a store hit, never both at once
    a_fill_wr_exclusive : assert property (
        @(posedge clk) !(fill_en_i && wr_en_i)
    ) else $error("data store fill and word write in the same cycle");

endmodule

/* rtl/dcache_ctrl.sv */
/*
 * Cache controller
 * One request at a time: lookup, read miss fill,
 * write-through and the core response handshake
 */
`timescale 1ns/1ps

module dcache_ctrl (
    input  logic                   clk,
    input  logic                   reset,

    input  logic                   core_req_valid_i,
    input  dcache_pkg::core_req_t  core_req_i,
    output logic                   core_req_ready_o,

    output logic                   core_rsp_valid_o,
    output dcache_pkg::core_rsp_t  core_rsp_o,
    input  logic                   core_rsp_ready_i,

    output logic                   mem_req_valid_o,
    output dcache_pkg::mem_req_t   mem_req_o,
    input  logic                   mem_req_ready_i,

    input  logic                   mem_rsp_valid_i,
    input  dcache_pkg::mem_rsp_t   mem_rsp_i,
    output logic                   mem_rsp_ready_o,

    output dcache_pkg::line_addr_t tag_lookup_addr_o,
    input  logic                   tag_hit_i,
    output logic                   tag_fill_en_o,

    output dcache_pkg::word_addr_t data_rd_addr_o,
    input  dcache_pkg::word_t      data_rd_word_i,
    output logic                   data_fill_en_o,
    output dcache_pkg::line_t      data_fill_line_o,
    output logic                   data_wr_en_o,
    output dcache_pkg::word_t      data_wr_word_o,

    output logic                   ev_read_o,
    output logic                   ev_write_o,
    output logic                   ev_read_miss_o,
    output logic                   ev_write_miss_o
);
    import dcache_pkg::*;

    ctrl_state_e state_q;
    ctrl_state_e state_d;

    core_req_t   req_q;
    word_t       rsp_data_q;

    logic        req_fire;
    logic        fill_fire;
    logic        is_read;
    logic        in_lookup;
    word_addr_t  cur_addr;
    line_addr_t  req_line_addr;
    wsel_t       req_wsel;

    assign req_fire  = core_req_valid_i && core_req_ready_o;
    assign fill_fire = mem_rsp_valid_i && mem_rsp_ready_o;
    assign is_read   = (req_q.op == OP_READ);
    assign in_lookup = (state_q == S_LOOKUP);

    assign req_line_addr = req_q.addr[ADDR_W-1:WSEL_W];
    assign req_wsel      = req_q.addr[WSEL_W-1:0];

    // Stores see the incoming address while idle, so results land in S_LOOKUP
    // Afterwards the held address also indexes fill and write
    assign cur_addr = (state_q == S_IDLE) ? core_req_i.addr : req_q.addr;

    assign tag_lookup_addr_o = cur_addr[ADDR_W-1:WSEL_W];
    assign data_rd_addr_o    = cur_addr;

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= S_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE: begin
                if (core_req_valid_i) begin
                    state_d = S_LOOKUP;
                end
            end
            S_LOOKUP: begin
                if (!is_read) begin
                    state_d = S_MEM_WR;
                end else if (tag_hit_i) begin
                    state_d = S_RESPOND;
                end else begin
                    state_d = S_MEM_RD;
                end
            end
            S_MEM_RD: begin
                if (mem_req_ready_i) begin
                    state_d = S_MEM_WAIT;
                end
            end
            S_MEM_WAIT: begin
                if (mem_rsp_valid_i) begin
                    state_d = S_RESPOND;
                end
            end
            S_MEM_WR: begin
                if (mem_req_ready_i) begin
                    state_d = S_RESPOND;
                end
            end
            S_RESPOND: begin
                if (core_rsp_ready_i) begin
                    state_d = S_IDLE;
                end
            end
            default: state_d = S_IDLE;
        endcase
    end

    // Request and response payload
    always_ff @(posedge clk) begin
        if (req_fire) begin
            req_q <= core_req_i;
        end
        if (in_lookup) begin
            // Writes echo their own data
            rsp_data_q <= is_read ? data_rd_word_i : req_q.data;
        end else if (fill_fire) begin
            rsp_data_q <= mem_rsp_i.line[req_wsel];
        end
    end

    assign core_req_ready_o = (state_q == S_IDLE);
    assign core_rsp_valid_o = (state_q == S_RESPOND);
    assign core_rsp_o       = '{data: rsp_data_q, tag: req_q.tag};

    assign mem_req_valid_o = (state_q == S_MEM_RD) || (state_q == S_MEM_WR);
    assign mem_req_o       = '{op:        req_q.op,
                               line_addr: req_line_addr,
                               wsel:      req_wsel,
                               data:      req_q.data};
    assign mem_rsp_ready_o = (state_q == S_MEM_WAIT);

    // Read miss refills both stores
    assign tag_fill_en_o    = fill_fire;
    assign data_fill_en_o   = fill_fire;
    assign data_fill_line_o = mem_rsp_i.line;

    // No allocate on write, only a hit updates the line
    assign data_wr_en_o   = in_lookup && !is_read && tag_hit_i;
    assign data_wr_word_o = req_q.data;

    assign ev_read_o       = in_lookup && is_read;
    assign ev_write_o      = in_lookup && !is_read;
    assign ev_read_miss_o  = in_lookup && is_read && !tag_hit_i;
    assign ev_write_miss_o = in_lookup && !is_read && !tag_hit_i;

    a_core_rsp_stable : assert property (
        @(posedge clk) disable iff (reset)
        core_rsp_valid_o && !core_rsp_ready_i |=> core_rsp_valid_o && $stable(core_rsp_o)
    ) else $error("core response changed under back-pressure");

    a_mem_req_stable : assert property (
        @(posedge clk) disable iff (reset)
        mem_req_valid_o && !mem_req_ready_i |=> mem_req_valid_o && $stable(mem_req_o)
    ) else $error("memory request changed before acceptance");

endmodule

/* rtl/dcache_perf.sv */
/*
 * Performance counters
 * Wrapping counts of reads, writes, read misses and write misses
 */
`timescale 1ns/1ps

module dcache_perf (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  ev_read_i,
    input  logic                  ev_write_i,
    input  logic                  ev_read_miss_i,
    input  logic                  ev_write_miss_i,
    output dcache_pkg::perf_cnt_t perf_o
);
    import dcache_pkg::*;

    perf_cnt_t perf_q;

    // Counters wrap on overflow
    always_ff @(posedge clk) begin
        if (reset) begin
            perf_q <= '0;
        end else begin
            if (ev_read_i) begin
                perf_q.reads <= perf_q.reads + 1'b1;
            end
            if (ev_write_i) begin
                perf_q.writes <= perf_q.writes + 1'b1;
            end
            if (ev_read_miss_i) begin
                perf_q.read_misses <= perf_q.read_misses + 1'b1;
            end
            if (ev_write_miss_i) begin
                perf_q.write_misses <= perf_q.write_misses + 1'b1;
            end
        end
    end

    assign perf_o = perf_q;

    // A miss is always counted together with its access
    a_read_miss_has_read : assert property (
        @(posedge clk) disable iff (reset)
        ev_read_miss_i |-> ev_read_i
    ) else $error("read miss event without read event");

    a_write_miss_has_write : assert property (
        @(posedge clk) disable iff (reset)
        ev_write_miss_i |-> ev_write_i
    ) else $error("write miss event without write event");

endmodule

/* rtl/dcache_top.sv */
/*
 * Data cache top level
 * Direct-mapped, write-through, read-allocate cache with
 * valid/ready core and memory ports and event counters
 */
`timescale 1ns/1ps

module dcache_top (
    input  logic                  clk,
    input  logic                  reset,

    input  logic                  core_req_valid_i,
    input  dcache_pkg::core_req_t core_req_i,
    output logic                  core_req_ready_o,

    output logic                  core_rsp_valid_o,
    output dcache_pkg::core_rsp_t core_rsp_o,
    input  logic                  core_rsp_ready_i,

    output logic                  mem_req_valid_o,
    output dcache_pkg::mem_req_t  mem_req_o,
    input  logic                  mem_req_ready_i,

    input  logic                  mem_rsp_valid_i,
    input  dcache_pkg::mem_rsp_t  mem_rsp_i,
    output logic                  mem_rsp_ready_o,

    output dcache_pkg::perf_cnt_t perf_o
);
    import dcache_pkg::*;

    line_addr_t tag_lookup_addr;
    logic       tag_hit;
    logic       tag_fill_en;

    word_addr_t data_rd_addr;
    word_t      data_rd_word;
    logic       data_fill_en;
    line_t      data_fill_line;
    logic       data_wr_en;
    word_t      data_wr_word;

    logic       ev_read;
    logic       ev_write;
    logic       ev_read_miss;
    logic       ev_write_miss;

    dcache_ctrl u_ctrl (
        .clk               (clk),
        .reset             (reset),
        .core_req_valid_i  (core_req_valid_i),
        .core_req_i        (core_req_i),
        .core_req_ready_o  (core_req_ready_o),
        .core_rsp_valid_o  (core_rsp_valid_o),
        .core_rsp_o        (core_rsp_o),
        .core_rsp_ready_i  (core_rsp_ready_i),
        .mem_req_valid_o   (mem_req_valid_o),
        .mem_req_o         (mem_req_o),
        .mem_req_ready_i   (mem_req_ready_i),
        .mem_rsp_valid_i   (mem_rsp_valid_i),
        .mem_rsp_i         (mem_rsp_i),
        .mem_rsp_ready_o   (mem_rsp_ready_o),
        .tag_lookup_addr_o (tag_lookup_addr),
        .tag_hit_i         (tag_hit),
        .tag_fill_en_o     (tag_fill_en),
        .data_rd_addr_o    (data_rd_addr),
        .data_rd_word_i    (data_rd_word),
        .data_fill_en_o    (data_fill_en),
        .data_fill_line_o  (data_fill_line),
        .data_wr_en_o      (data_wr_en),
        .data_wr_word_o    (data_wr_word),
        .ev_read_o         (ev_read),
        .ev_write_o        (ev_write),
        .ev_read_miss_o    (ev_read_miss),
        .ev_write_miss_o   (ev_write_miss)
    );

    // Outside S_IDLE the lookup addresses carry the held request address
    dcache_tag_store u_tags (
        .clk           (clk),
        .reset         (reset),
        .lookup_addr_i (tag_lookup_addr),
        .hit_o         (tag_hit),
        .fill_en_i     (tag_fill_en),
        .fill_addr_i   (tag_lookup_addr)
    );

    dcache_data_store u_data (
        .clk          (clk),
        .rd_addr_i    (data_rd_addr),
        .rd_word_o    (data_rd_word),
        .fill_en_i    (data_fill_en),
        .fill_index_i (data_rd_addr[WSEL_W +: INDEX_W]),
        .fill_line_i  (data_fill_line),
        .wr_en_i      (data_wr_en),
        .wr_addr_i    (data_rd_addr),
        .wr_word_i    (data_wr_word)
    );

    dcache_perf u_perf (
        .clk             (clk),
        .reset           (reset),
        .ev_read_i       (ev_read),
        .ev_write_i      (ev_write),
        .ev_read_miss_i  (ev_read_miss),
        .ev_write_miss_i (ev_write_miss),
        .perf_o          (perf_o)
    );

endmodule

/* test/tb_dcache.sv */
/*
 * Data cache testbench
 * Table-driven core requests against a memory model,
 * checked with a direct-mapped write-through reference model
 */
`timescale 1ns/1ps

module tb_dcache;
    import dcache_pkg::*;

    localparam int NUM_ROWS       = 16;
    localparam int TIMEOUT_CYCLES = 64;
    localparam int BP_CYCLES      = 4;
    localparam int MEM_LINES      = 256;

    typedef struct packed {
        req_op_e    op;
        word_addr_t addr;
        word_t      wdata;
        logic       bp;
        logic       exp_miss;
    } row_t;

    logic      clk;
    logic      reset;
    logic      core_req_valid_i;
    core_req_t core_req_i;
    logic      core_req_ready_o;
    logic      core_rsp_valid_o;
    core_rsp_t core_rsp_o;
    logic      core_rsp_ready_i;
    logic      mem_req_valid_o;
    mem_req_t  mem_req_o;
    logic      mem_req_ready_i;
    logic      mem_rsp_valid_i;
    mem_rsp_t  mem_rsp_i;
    logic      mem_rsp_ready_o;
    perf_cnt_t perf_o;

    line_t                mem_model [MEM_LINES];
    line_t                ref_mem   [MEM_LINES];
    logic [NUM_LINES-1:0] ref_valid;
    cache_tag_t           ref_tag   [NUM_LINES];
    perf_cnt_t            ref_perf;
    logic [31:0]          rng_state;
    int                   mem_rd_count;
    int                   mem_wr_count;
    mem_req_t             last_mem_rd;
    mem_req_t             last_mem_wr;
    row_t                 rows [NUM_ROWS];
    int                   errors;
    int                   tests;
    logic                 timed_out;

    dcache_top u_dcache_top (
        .clk              (clk),
        .reset            (reset),
        .core_req_valid_i (core_req_valid_i),
        .core_req_i       (core_req_i),
        .core_req_ready_o (core_req_ready_o),
        .core_rsp_valid_o (core_rsp_valid_o),
        .core_rsp_o       (core_rsp_o),
        .core_rsp_ready_i (core_rsp_ready_i),
        .mem_req_valid_o  (mem_req_valid_o),
        .mem_req_o        (mem_req_o),
        .mem_req_ready_i  (mem_req_ready_i),
        .mem_rsp_valid_i  (mem_rsp_valid_i),
        .mem_rsp_i        (mem_rsp_i),
        .mem_rsp_ready_o  (mem_rsp_ready_o),
        .perf_o           (perf_o)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    // 32-bit xorshift
    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // Memory side: random ready delay, random read latency, one line per read
    initial begin : memory_model
        logic       req_seen;
        int         req_wait;
        logic       rd_pending;
        int         rsp_wait;
        line_addr_t rsp_line;
        logic       next_req_ready;
        logic       next_rsp_valid;
        mem_req_ready_i = 1'b0;
        mem_rsp_valid_i = 1'b0;
        mem_rsp_i       = '0;
        mem_rd_count    = 0;
        mem_wr_count    = 0;
        last_mem_rd     = '0;
        last_mem_wr     = '0;
        req_seen        = 1'b0;
        req_wait        = 0;
        rd_pending      = 1'b0;
        rsp_wait        = 0;
        rsp_line        = '0;
        forever begin
            @(negedge clk);
            next_req_ready = 1'b0;
            next_rsp_valid = mem_rsp_valid_i;
            if (!reset) begin
                if (mem_req_valid_o && mem_req_ready_i) begin
                    req_seen = 1'b0;
                    if (mem_req_o.op == OP_WRITE) begin
                        mem_model[mem_req_o.line_addr][mem_req_o.wsel] = mem_req_o.data;
                        mem_wr_count++;
                        last_mem_wr = mem_req_o;
                    end else begin
                        mem_rd_count++;
                        last_mem_rd = mem_req_o;
                        rd_pending  = 1'b1;
                        rsp_line    = mem_req_o.line_addr;
                        rsp_wait    = next_rand() % 4;
                    end
                end else if (mem_req_valid_o) begin
                    if (!req_seen) begin
                        req_seen = 1'b1;
                        req_wait = next_rand() % 4;
                    end
                    if (req_wait == 0) begin
                        next_req_ready = 1'b1;
                    end else begin
                        req_wait--;
                    end
                end
                if (mem_rsp_valid_i && mem_rsp_ready_o) begin
                    next_rsp_valid = 1'b0;
                    rd_pending     = 1'b0;
                end else if (rd_pending && !mem_rsp_valid_i) begin
                    if (rsp_wait == 0) begin
                        next_rsp_valid = 1'b1;
                    end else begin
                        rsp_wait--;
                    end
                end
            end
            @(posedge clk);
            #1;
            mem_req_ready_i = next_req_ready;
            mem_rsp_valid_i = next_rsp_valid;
            mem_rsp_i.line  = mem_model[rsp_line];
        end
    end

    task automatic fill_memory();
        for (int l = 0; l < MEM_LINES; l++) begin
            for (int w = 0; w < WORDS_PER_LINE; w++) begin
                mem_model[l][w] = next_rand() ^ word_t'((l << WSEL_W) | w);
                ref_mem[l][w]   = mem_model[l][w];
            end
        end
        ref_valid = '0;
        ref_perf  = '0;
    endtask

    task automatic load_table();
        // op, address, write data, back-pressure, expected miss
        rows[0]  = '{OP_READ,  10'h049, 32'h0000_0000, 1'b0, 1'b1};
        rows[1]  = '{OP_READ,  10'h048, 32'h0000_0000, 1'b0, 1'b0};
        rows[2]  = '{OP_READ,  10'h04B, 32'h0000_0000, 1'b0, 1'b0};
        rows[3]  = '{OP_READ,  10'h04A, 32'h0000_0000, 1'b0, 1'b0};
        rows[4]  = '{OP_WRITE, 10'h049, 32'hCAFE_0001, 1'b0, 1'b0};
        rows[5]  = '{OP_WRITE, 10'h1F0, 32'h0BAD_F00D, 1'b0, 1'b1};
        rows[6]  = '{OP_READ,  10'h049, 32'h0000_0000, 1'b0, 1'b0};
        rows[7]  = '{OP_READ,  10'h1F0, 32'h0000_0000, 1'b0, 1'b1};
        // Same index 2, tags 3 and 1 evict each other
        rows[8]  = '{OP_READ,  10'h0CA, 32'h0000_0000, 1'b0, 1'b1};
        rows[9]  = '{OP_READ,  10'h049, 32'h0000_0000, 1'b0, 1'b1};
        rows[10] = '{OP_READ,  10'h0CA, 32'h0000_0000, 1'b0, 1'b1};
        rows[11] = '{OP_READ,  10'h04B, 32'h0000_0000, 1'b0, 1'b1};
        rows[12] = '{OP_READ,  10'h04A, 32'h0000_0000, 1'b1, 1'b0};
        rows[13] = '{OP_WRITE, 10'h04A, 32'h1234_5678, 1'b1, 1'b0};
        rows[14] = '{OP_READ,  10'h04A, 32'h0000_0000, 1'b0, 1'b0};
        rows[15] = '{OP_READ,  10'h3FF, 32'h0000_0000, 1'b1, 1'b1};
    endtask

    // Direct-mapped, read-allocate, write-through, no allocate on write
    function automatic core_rsp_t predict(row_t row, req_tag_t tag);
        line_addr_t line;
        wsel_t      wsel;
        index_t     idx;
        cache_tag_t ctag;
        logic       hit;
        core_rsp_t  rsp;
        line = row.addr[ADDR_W-1:WSEL_W];
        wsel = row.addr[WSEL_W-1:0];
        idx  = line[INDEX_W-1:0];
        ctag = line[CTAG_W+INDEX_W-1:INDEX_W];
        hit  = ref_valid[idx] && (ref_tag[idx] == ctag);
        rsp.tag = tag;
        if (row.op == OP_READ) begin
            rsp.data = ref_mem[line][wsel];
            ref_perf.reads = ref_perf.reads + 1'b1;
            if (!hit) begin
                ref_perf.read_misses = ref_perf.read_misses + 1'b1;
                ref_valid[idx] = 1'b1;
                ref_tag[idx]   = ctag;
            end
        end else begin
            rsp.data = row.wdata;
            ref_mem[line][wsel] = row.wdata;
            ref_perf.writes = ref_perf.writes + 1'b1;
            if (!hit) begin
                ref_perf.write_misses = ref_perf.write_misses + 1'b1;
            end
        end
        return rsp;
    endfunction

    task automatic check_rsp(core_rsp_t got, core_rsp_t exp, string name);
        if (got !== exp) begin
            $display("CHECK FAILED time %0d ns: %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_perf(perf_cnt_t got, perf_cnt_t exp, string name);
        if (got !== exp) begin
            $display("CHECK FAILED time %0d ns: %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_mem_reqs(int got, int exp, string name);
        if (got != exp) begin
            $display("CHECK FAILED time %0d ns: %s got %0d expected %0d",
                     $time, name, got, exp);
            errors++;
        end
    endtask

    // Word select and data only matter for writes
    task automatic check_mem_req(mem_req_t got, mem_req_t exp, string name);
        logic bad;
        bad = (got.op !== exp.op) || (got.line_addr !== exp.line_addr);
        if (exp.op == OP_WRITE) begin
            bad = bad || (got.wsel !== exp.wsel) || (got.data !== exp.data);
        end
        if (bad) begin
            $display("CHECK FAILED time %0d ns: %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic report_timeout(string what);
        $display("Timeout at %0d ns: %s", $time, what);
        errors++;
        timed_out = 1'b1;
    endtask

    task automatic run_row(int idx);
        row_t      row;
        core_rsp_t exp_rsp;
        core_rsp_t held;
        mem_req_t  exp_req;
        int        rd_before;
        int        wr_before;
        int        err_before;
        int        cycles;
        int        k;
        row        = rows[idx];
        err_before = errors;
        rd_before  = mem_rd_count;
        wr_before  = mem_wr_count;
        exp_rsp    = predict(row, req_tag_t'(idx));
        @(posedge clk);
        #1;
        core_req_valid_i = 1'b1;
        core_req_i = '{op: row.op, addr: row.addr, data: row.wdata, tag: req_tag_t'(idx)};
        core_rsp_ready_i = !row.bp;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!core_req_ready_o && cycles < TIMEOUT_CYCLES);
        if (!core_req_ready_o) begin
            report_timeout("core request never accepted");
            return;
        end
        @(posedge clk);
        #1;
        core_req_valid_i = 1'b0;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!core_rsp_valid_o && cycles < TIMEOUT_CYCLES);
        if (!core_rsp_valid_o) begin
            report_timeout("no core response");
            return;
        end
        held = core_rsp_o;
        if (row.bp) begin
            for (k = 0; k < BP_CYCLES; k++) begin
                @(negedge clk);
                if (!core_rsp_valid_o) begin
                    $display("Error at %0d ns: response valid dropped while ready low", $time);
                    errors++;
                end
                check_rsp(core_rsp_o, held, "core_rsp_o under back-pressure");
            end
            @(posedge clk);
            #1;
            core_rsp_ready_i = 1'b1;
            @(negedge clk);
            if (!core_rsp_valid_o) begin
                $display("Error at %0d ns: response gone before ready rose", $time);
                errors++;
            end
            // Transfer happens on the next edge, then valid must drop
            @(negedge clk);
            if (core_rsp_valid_o) begin
                $display("Error at %0d ns: response still valid after transfer", $time);
                errors++;
            end
        end
        check_rsp(held, exp_rsp, "core_rsp_o");
        // Memory traffic of this request
        if (row.op == OP_READ) begin
            check_mem_reqs(mem_rd_count - rd_before, row.exp_miss ? 1 : 0, "memory reads");
            check_mem_reqs(mem_wr_count - wr_before, 0, "memory writes");
            if (row.exp_miss) begin
                exp_req = '{op: OP_READ, line_addr: row.addr[ADDR_W-1:WSEL_W],
                            wsel: '0, data: '0};
                check_mem_req(last_mem_rd, exp_req, "mem_req_o read");
            end
        end else begin
            check_mem_reqs(mem_rd_count - rd_before, 0, "memory reads");
            check_mem_reqs(mem_wr_count - wr_before, 1, "memory writes");
            exp_req = '{op: OP_WRITE, line_addr: row.addr[ADDR_W-1:WSEL_W],
                        wsel: row.addr[WSEL_W-1:0], data: row.wdata};
            check_mem_req(last_mem_wr, exp_req, "mem_req_o write");
        end
        tests++;
        $display("test %0d %s addr %h: %s", idx, (row.op == OP_READ) ? "read" : "write",
                 row.addr, (errors == err_before) ? "ok" : "FAILED");
    endtask

    initial begin : main
        int i;
        errors           = 0;
        tests            = 0;
        timed_out        = 1'b0;
        reset            = 1'b1;
        core_req_valid_i = 1'b0;
        core_req_i       = '0;
        core_rsp_ready_i = 1'b0;
        rng_state        = 32'd73886;
        fill_memory();
        load_table();
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
        @(negedge clk);
        check_perf(perf_o, '0, "perf_o after reset");
        for (i = 0; i < NUM_ROWS && !timed_out; i++) begin
            run_row(i);
        end
        if (!timed_out) begin
            @(negedge clk);
            check_perf(perf_o, ref_perf, "perf_o");
        end
        $display("tests run %0d of %0d, errors %0d", tests, NUM_ROWS, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* verilog.f */
rtl/dcache_pkg.sv
rtl/dcache_tag_store.sv
rtl/dcache_data_store.sv
rtl/dcache_ctrl.sv
rtl/dcache_perf.sv
rtl/dcache_top.sv
test/tb_dcache.sv
